//--- Bender.yml
package:
  name: axi_wr_bridge

sources:
  - hw/axi_wr_pkg.sv
  - hw/aw_decoder.sv
  - hw/w_router.sv
  - hw/b_return.sv
  - hw/axi_wr_bridge.sv
  - target: simulation
    files:
      - sim/axi_slave_model.sv
      - sim/tb_axi_wr_bridge.sv

//--- hw/aw_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module aw_decoder #(
  parameter int ADDR_W = axi_wr_pkg::ADDR_W_DEF
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [ADDR_W-1:0]      aw_addr,
  input  logic                   aw_valid,
  input  logic                   aw_ready_s0,
  input  logic                   aw_ready_s1,
  input  logic                   aw_ready_s2,
  input  logic                   data_done,
  input  logic                   resp_done,
  output logic                   aw_ready,
  output logic                   aw_valid_s0,
  output logic                   aw_valid_s1,
  output logic                   aw_valid_s2,
  output axi_wr_pkg::wr_lock_t   lock,
  output axi_wr_pkg::slave_idx_t target
);

  localparam int SEL_TOP = ADDR_W - 1 - axi_wr_pkg::SEL_HI;

  logic [axi_wr_pkg::SEL_W-1:0]      sel;
  axi_wr_pkg::slave_idx_t            dec_idx;
  logic [axi_wr_pkg::NUM_SLAVES-1:0] ready_vec;
  logic [axi_wr_pkg::NUM_SLAVES-1:0] valid_vec;
  logic                              idle;
  logic                              aw_hs;
  axi_wr_pkg::wr_lock_t              lock_next;

  assign sel = aw_addr[SEL_TOP -: axi_wr_pkg::SEL_W];

  // Address map decode
  always_comb begin
    if (sel == axi_wr_pkg::SEL_SLV0) begin
      dec_idx = axi_wr_pkg::SLV0;
    end else if (sel == axi_wr_pkg::SEL_SLV1) begin
      dec_idx = axi_wr_pkg::SLV1;
    end else begin
      dec_idx = axi_wr_pkg::SLV2;
    end
  end

  assign idle      = (lock == axi_wr_pkg::LOCK_IDLE);
  assign ready_vec = {aw_ready_s2, aw_ready_s1, aw_ready_s0};

  // AW only open while no transaction holds the lock
  always_comb begin
    valid_vec          = '0;
    valid_vec[dec_idx] = idle & aw_valid;
  end

  assign aw_valid_s0 = valid_vec[0];
  assign aw_valid_s1 = valid_vec[1];
  assign aw_valid_s2 = valid_vec[2];

  assign aw_ready = idle & ready_vec[dec_idx];
  assign aw_hs    = aw_valid & aw_ready;

  always_comb begin
    lock_next = lock;
    unique case (lock)
      axi_wr_pkg::LOCK_IDLE: begin
        if (aw_hs) lock_next = axi_wr_pkg::LOCK_DATA;
      end
      axi_wr_pkg::LOCK_DATA: begin
        if (data_done) lock_next = axi_wr_pkg::LOCK_RESP;
      end
      axi_wr_pkg::LOCK_RESP: begin
        if (resp_done) lock_next = axi_wr_pkg::LOCK_IDLE;
      end
      default: lock_next = axi_wr_pkg::LOCK_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock   <= axi_wr_pkg::LOCK_IDLE;
      target <= axi_wr_pkg::SLV0;
    end else begin
      lock <= lock_next;
      // Target held until the response completes
      if (aw_hs) target <= dec_idx;
    end
  end

endmodule

`default_nettype wire

//--- hw/axi_wr_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_bridge #(
  parameter int ADDR_W = axi_wr_pkg::ADDR_W_DEF,
  parameter int DATA_W = axi_wr_pkg::DATA_W_DEF
) (
  input  logic                clk,
  input  logic                rstn,
  // Master
  input  logic [ADDR_W-1:0]   aw_addr,
  input  logic                aw_valid,
  output logic                aw_ready,
  input  logic [DATA_W-1:0]   w_data,
  input  logic [DATA_W/8-1:0] w_strb,
  input  logic                w_last,
  input  logic                w_valid,
  output logic                w_ready,
  output logic [1:0]          b_resp,
  output logic                b_valid,
  input  logic                b_ready,
  // Slave 0
  output logic [ADDR_W-1:0]   aw_addr_s0,
  output logic                aw_valid_s0,
  input  logic                aw_ready_s0,
  output logic [DATA_W-1:0]   w_data_s0,
  output logic [DATA_W/8-1:0] w_strb_s0,
  output logic                w_last_s0,
  output logic                w_valid_s0,
  input  logic                w_ready_s0,
  input  logic [1:0]          b_resp_s0,
  input  logic                b_valid_s0,
  output logic                b_ready_s0,
  // Slave 1
  output logic [ADDR_W-1:0]   aw_addr_s1,
  output logic                aw_valid_s1,
  input  logic                aw_ready_s1,
  output logic [DATA_W-1:0]   w_data_s1,
  output logic [DATA_W/8-1:0] w_strb_s1,
  output logic                w_last_s1,
  output logic                w_valid_s1,
  input  logic                w_ready_s1,
  input  logic [1:0]          b_resp_s1,
  input  logic                b_valid_s1,
  output logic                b_ready_s1,
  // Slave 2
  output logic [ADDR_W-1:0]   aw_addr_s2,
  output logic                aw_valid_s2,
  input  logic                aw_ready_s2,
  output logic [DATA_W-1:0]   w_data_s2,
  output logic [DATA_W/8-1:0] w_strb_s2,
  output logic                w_last_s2,
  output logic                w_valid_s2,
  input  logic                w_ready_s2,
  input  logic [1:0]          b_resp_s2,
  input  logic                b_valid_s2,
  output logic                b_ready_s2
);

  axi_wr_pkg::wr_lock_t   lock;
  axi_wr_pkg::slave_idx_t target;
  logic                   data_done;
  logic                   resp_done;

  // Address fans out, only valid is steered
  assign aw_addr_s0 = aw_addr;
  assign aw_addr_s1 = aw_addr;
  assign aw_addr_s2 = aw_addr;

  aw_decoder #(
    .ADDR_W (ADDR_W)
  ) aw_decoder_i (
    .clk         (clk),
    .rstn        (rstn),
    .aw_addr     (aw_addr),
    .aw_valid    (aw_valid),
    .aw_ready_s0 (aw_ready_s0),
    .aw_ready_s1 (aw_ready_s1),
    .aw_ready_s2 (aw_ready_s2),
    .data_done   (data_done),
    .resp_done   (resp_done),
    .aw_ready    (aw_ready),
    .aw_valid_s0 (aw_valid_s0),
    .aw_valid_s1 (aw_valid_s1),
    .aw_valid_s2 (aw_valid_s2),
    .lock        (lock),
    .target      (target)
  );

  w_router #(
    .DATA_W (DATA_W)
  ) w_router_i (
    .clk        (clk),
    .rstn       (rstn),
    .lock       (lock),
    .target     (target),
    .w_data     (w_data),
    .w_strb     (w_strb),
    .w_last     (w_last),
    .w_valid    (w_valid),
    .w_ready_s0 (w_ready_s0),
    .w_ready_s1 (w_ready_s1),
    .w_ready_s2 (w_ready_s2),
    .w_ready    (w_ready),
    .w_data_s0  (w_data_s0),
    .w_strb_s0  (w_strb_s0),
    .w_last_s0  (w_last_s0),
    .w_valid_s0 (w_valid_s0),
    .w_data_s1  (w_data_s1),
    .w_strb_s1  (w_strb_s1),
    .w_last_s1  (w_last_s1),
    .w_valid_s1 (w_valid_s1),
    .w_data_s2  (w_data_s2),
    .w_strb_s2  (w_strb_s2),
    .w_last_s2  (w_last_s2),
    .w_valid_s2 (w_valid_s2),
    .data_done  (data_done)
  );

  b_return b_return_i (
    .lock       (lock),
    .target     (target),
    .b_resp_s0  (b_resp_s0),
    .b_valid_s0 (b_valid_s0),
    .b_resp_s1  (b_resp_s1),
    .b_valid_s1 (b_valid_s1),
    .b_resp_s2  (b_resp_s2),
    .b_valid_s2 (b_valid_s2),
    .b_ready    (b_ready),
    .b_resp     (b_resp),
    .b_valid    (b_valid),
    .b_ready_s0 (b_ready_s0),
    .b_ready_s1 (b_ready_s1),
    .b_ready_s2 (b_ready_s2),
    .resp_done  (resp_done)
  );

endmodule

`default_nettype wire

//--- hw/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

  // Slave ports on the interconnect
  localparam int NUM_SLAVES = 3;

  // Top-level defaults
  localparam int ADDR_W_DEF = 32;
  localparam int DATA_W_DEF = 32;

  // Index of the slave a transaction is locked to
  typedef logic [1:0] slave_idx_t;

  localparam slave_idx_t SLV0 = 2'd0;
  localparam slave_idx_t SLV1 = 2'd1;
  localparam slave_idx_t SLV2 = 2'd2;

  // Write transaction state
  typedef enum logic [1:0] {
    LOCK_IDLE = 2'd0,
    LOCK_DATA = 2'd1,
    LOCK_RESP = 2'd2
  } wr_lock_t;

  // Select field sits at the top of AWADDR, offset down from the MSB
  localparam int SEL_HI = 0;
  localparam int SEL_W  = 2;

  // Address map on the select field
  // 00 -> slave 0, 01 -> slave 1, 1x -> slave 2
  localparam logic [SEL_W-1:0] SEL_SLV0 = 2'b00;
  localparam logic [SEL_W-1:0] SEL_SLV1 = 2'b01;

endpackage

`default_nettype wire

//--- hw/b_return.sv
`timescale 1ns/1ps
`default_nettype none

module b_return (
  input  axi_wr_pkg::wr_lock_t   lock,
  input  axi_wr_pkg::slave_idx_t target,
  input  logic [1:0]             b_resp_s0,
  input  logic                   b_valid_s0,
  input  logic [1:0]             b_resp_s1,
  input  logic                   b_valid_s1,
  input  logic [1:0]             b_resp_s2,
  input  logic                   b_valid_s2,
  input  logic                   b_ready,
  output logic [1:0]             b_resp,
  output logic                   b_valid,
  output logic                   b_ready_s0,
  output logic                   b_ready_s1,
  output logic                   b_ready_s2,
  output logic                   resp_done
);

  logic [axi_wr_pkg::NUM_SLAVES-1:0] valid_vec;
  logic [axi_wr_pkg::NUM_SLAVES-1:0] ready_vec;
  logic                              active;

  assign active    = (lock == axi_wr_pkg::LOCK_RESP);
  assign valid_vec = {b_valid_s2, b_valid_s1, b_valid_s0};

  // Only the locked slave's response reaches the master
  always_comb begin
    b_resp = 2'b00;
    if (active) begin
      unique case (target)
        axi_wr_pkg::SLV0: b_resp = b_resp_s0;
        axi_wr_pkg::SLV1: b_resp = b_resp_s1;
        default:          b_resp = b_resp_s2;
      endcase
    end
  end

  assign b_valid = active & valid_vec[target];

  always_comb begin
    ready_vec         = '0;
    ready_vec[target] = active & b_ready;
  end

  assign b_ready_s0 = ready_vec[0];
  assign b_ready_s1 = ready_vec[1];
  assign b_ready_s2 = ready_vec[2];

  assign resp_done = b_valid & b_ready;

endmodule

`default_nettype wire

//--- hw/w_router.sv
`timescale 1ns/1ps
`default_nettype none

module w_router #(
  parameter int DATA_W = axi_wr_pkg::DATA_W_DEF
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  axi_wr_pkg::wr_lock_t   lock,
  input  axi_wr_pkg::slave_idx_t target,
  input  logic [DATA_W-1:0]      w_data,
  input  logic [DATA_W/8-1:0]    w_strb,
  input  logic                   w_last,
  input  logic                   w_valid,
  input  logic                   w_ready_s0,
  input  logic                   w_ready_s1,
  input  logic                   w_ready_s2,
  output logic                   w_ready,
  output logic [DATA_W-1:0]      w_data_s0,
  output logic [DATA_W/8-1:0]    w_strb_s0,
  output logic                   w_last_s0,
  output logic                   w_valid_s0,
  output logic [DATA_W-1:0]      w_data_s1,
  output logic [DATA_W/8-1:0]    w_strb_s1,
  output logic                   w_last_s1,
  output logic                   w_valid_s1,
  output logic [DATA_W-1:0]      w_data_s2,
  output logic [DATA_W/8-1:0]    w_strb_s2,
  output logic                   w_last_s2,
  output logic                   w_valid_s2,
  output logic                   data_done
);

  localparam int STRB_W = DATA_W / 8;

  logic [axi_wr_pkg::NUM_SLAVES-1:0] ready_vec;
  logic [axi_wr_pkg::NUM_SLAVES-1:0] sel_vec;
  logic                              active;
  logic                              w_hs;

  assign active    = (lock == axi_wr_pkg::LOCK_DATA);
  assign ready_vec = {w_ready_s2, w_ready_s1, w_ready_s0};

  // One-hot select of the locked slave, empty outside the data phase
  always_comb begin
    sel_vec         = '0;
    sel_vec[target] = active;
  end

  assign w_ready = active & ready_vec[target];

  // Slave 0
  assign w_valid_s0 = sel_vec[0] & w_valid;
  assign w_data_s0  = sel_vec[0] ? w_data : '0;
  assign w_strb_s0  = sel_vec[0] ? w_strb : {STRB_W{1'b0}};
  assign w_last_s0  = sel_vec[0] & w_last;

  // Slave 1
  assign w_valid_s1 = sel_vec[1] & w_valid;
  assign w_data_s1  = sel_vec[1] ? w_data : '0;
  assign w_strb_s1  = sel_vec[1] ? w_strb : {STRB_W{1'b0}};
  assign w_last_s1  = sel_vec[1] & w_last;

  // Slave 2
  assign w_valid_s2 = sel_vec[2] & w_valid;
  assign w_data_s2  = sel_vec[2] ? w_data : '0;
  assign w_strb_s2  = sel_vec[2] ? w_strb : {STRB_W{1'b0}};
  assign w_last_s2  = sel_vec[2] & w_last;

  assign w_hs      = w_valid & w_ready;
  assign data_done = w_hs & w_last;

endmodule

`default_nettype wire

//--- project.f
hw/axi_wr_pkg.sv
hw/aw_decoder.sv
hw/w_router.sv
hw/b_return.sv
hw/axi_wr_bridge.sv
sim/axi_slave_model.sv
sim/tb_axi_wr_bridge.sv

//--- sim/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model #(
  parameter int ADDR_W    = 32,
  parameter int DATA_W    = 32,
  parameter int SLV_ID    = 0,
  parameter int STALL_PCT = 30
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic [ADDR_W-1:0]   aw_addr,
  input  logic                aw_valid,
  output logic                aw_ready,
  input  logic [DATA_W-1:0]   w_data,
  input  logic [DATA_W/8-1:0] w_strb,
  input  logic                w_last,
  input  logic                w_valid,
  output logic                w_ready,
  output logic [1:0]          b_resp,
  output logic                b_valid,
  input  logic                b_ready
);

  localparam int BEAT_W = DATA_W + DATA_W / 8 + 1;

  // Everything accepted, read by the testbench top at the end
  logic [ADDR_W-1:0] aw_log [$];
  logic [BEAT_W-1:0] w_log [$];

  int   bursts_open;
  logic b_done;
  logic in_reset;

  function automatic logic roll_ready();
    return ($urandom % 100) >= STALL_PCT;
  endfunction

  // Response carries the slave number so the master can tell who answered
  assign b_resp = 2'(SLV_ID);

  initial begin
    aw_ready    = 1'b0;
    w_ready     = 1'b0;
    b_valid     = 1'b0;
    bursts_open = 0;
    b_done      = 1'b0;
  end

  always @(posedge clk) begin
    in_reset = !rstn;
    b_done   = 1'b0;
    if (!in_reset) begin
      if (aw_valid && aw_ready) aw_log.push_back(aw_addr);
      if (w_valid && w_ready) begin
        w_log.push_back({w_last, w_strb, w_data});
        if (w_last) bursts_open++;
      end
      b_done = b_valid && b_ready;
    end
    #1;
    if (in_reset) begin
      aw_ready    = 1'b0;
      w_ready     = 1'b0;
      b_valid     = 1'b0;
      bursts_open = 0;
    end else begin
      aw_ready = roll_ready();
      w_ready  = roll_ready();
      if (b_done) begin
        b_valid = 1'b0;
      end else if (!b_valid && bursts_open > 0 && roll_ready()) begin
        b_valid = 1'b1;
        bursts_open--;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_axi_wr_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_bridge;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = DATA_W / 8;
  localparam int BEAT_W     = DATA_W + STRB_W + 1;
  localparam int N_TXN      = 200;
  localparam int MAX_BURST  = 8;
  localparam int STALL_PCT  = 30;
  localparam int CLK_PERIOD = 20;
  localparam int TIMEOUT_NS = N_TXN * MAX_BURST * 40 * CLK_PERIOD;

  logic              clk;
  logic              rstn;
  logic [ADDR_W-1:0] aw_addr;
  logic              aw_valid, aw_ready;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              w_last, w_valid, w_ready;
  logic [1:0]        b_resp;
  logic              b_valid, b_ready;

  logic [ADDR_W-1:0] aw_addr_s0, aw_addr_s1, aw_addr_s2;
  logic              aw_valid_s0, aw_valid_s1, aw_valid_s2;
  logic              aw_ready_s0, aw_ready_s1, aw_ready_s2;
  logic [DATA_W-1:0] w_data_s0, w_data_s1, w_data_s2;
  logic [STRB_W-1:0] w_strb_s0, w_strb_s1, w_strb_s2;
  logic              w_last_s0, w_last_s1, w_last_s2;
  logic              w_valid_s0, w_valid_s1, w_valid_s2;
  logic              w_ready_s0, w_ready_s1, w_ready_s2;
  logic [1:0]        b_resp_s0, b_resp_s1, b_resp_s2;
  logic              b_valid_s0, b_valid_s1, b_valid_s2;
  logic              b_ready_s0, b_ready_s1, b_ready_s2;

  // Expected traffic per slave
  logic [ADDR_W-1:0] exp_aw [3][$];
  logic [BEAT_W-1:0] exp_w [3][$];

  int          value_errs;
  int          proto_errs;
  int          b_count;
  int          cur_slave;
  int          post_reset;
  logic        in_flight;
  logic [2:0]  tgt_mask;

  axi_wr_bridge #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) axi_wr_bridge_i (.*);

  axi_slave_model #(.SLV_ID(0), .STALL_PCT(STALL_PCT)) slv0_i (
    .clk(clk), .rstn(rstn),
    .aw_addr(aw_addr_s0), .aw_valid(aw_valid_s0), .aw_ready(aw_ready_s0),
    .w_data(w_data_s0), .w_strb(w_strb_s0), .w_last(w_last_s0),
    .w_valid(w_valid_s0), .w_ready(w_ready_s0),
    .b_resp(b_resp_s0), .b_valid(b_valid_s0), .b_ready(b_ready_s0)
  );

  axi_slave_model #(.SLV_ID(1), .STALL_PCT(STALL_PCT)) slv1_i (
    .clk(clk), .rstn(rstn),
    .aw_addr(aw_addr_s1), .aw_valid(aw_valid_s1), .aw_ready(aw_ready_s1),
    .w_data(w_data_s1), .w_strb(w_strb_s1), .w_last(w_last_s1),
    .w_valid(w_valid_s1), .w_ready(w_ready_s1),
    .b_resp(b_resp_s1), .b_valid(b_valid_s1), .b_ready(b_ready_s1)
  );

  axi_slave_model #(.SLV_ID(2), .STALL_PCT(STALL_PCT)) slv2_i (
    .clk(clk), .rstn(rstn),
    .aw_addr(aw_addr_s2), .aw_valid(aw_valid_s2), .aw_ready(aw_ready_s2),
    .w_data(w_data_s2), .w_strb(w_strb_s2), .w_last(w_last_s2),
    .w_valid(w_valid_s2), .w_ready(w_ready_s2),
    .b_resp(b_resp_s2), .b_valid(b_valid_s2), .b_ready(b_ready_s2)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Two top address bits pick the slave, 1x all land on slave 2
  function automatic int slave_of(input logic [ADDR_W-1:0] addr);
    if (addr[ADDR_W-1]) return 2;
    return addr[ADDR_W-2] ? 1 : 0;
  endfunction

  always @(posedge clk) begin
    if (!rstn || post_reset < 2) begin
      assert (!(aw_valid_s0 | aw_valid_s1 | aw_valid_s2 | w_valid_s0 | w_valid_s1
                | w_valid_s2 | b_ready_s0 | b_ready_s1 | b_ready_s2 | w_ready | b_valid))
      else begin
        proto_errs++;
        $display("Reset: a slave valid, w_ready or b_valid is high at %0t", $time);
      end
    end
    if (rstn) begin
      tgt_mask = 3'b001 << cur_slave;
      assert ((({aw_valid_s2, aw_valid_s1, aw_valid_s0} & ~tgt_mask) == 3'b000) &&
              (({w_valid_s2, w_valid_s1, w_valid_s0} & ~tgt_mask) == 3'b000) &&
              (({b_ready_s2, b_ready_s1, b_ready_s0} & ~tgt_mask) == 3'b000))
      else begin
        proto_errs++;
        $display("Routing: a non-target slave saw a valid or b_ready at %0t", $time);
      end
      assert (!w_ready || in_flight)
      else begin
        proto_errs++;
        $display("Ordering: w_ready high before the AW handshake at %0t", $time);
      end
      // AW stays closed from its handshake until the B handshake
      assert (!(aw_ready && in_flight))
      else begin
        proto_errs++;
        $display("Ordering: aw_ready high while a write is in flight at %0t", $time);
      end
      if (aw_valid && aw_ready) begin
        in_flight = 1'b1;
      end
      if (b_valid && b_ready) begin
        in_flight = 1'b0;
        b_count++;
      end
    end
    if (!rstn) post_reset = 0;
    else if (post_reset < 2) post_reset++;
  end

  // One full write: AW, a random burst with gaps, then B under stalls
  task automatic run_txn();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    int                len;
    int                gap;
    bit                done;
    addr      = $urandom;
    len       = 1 + $urandom % MAX_BURST;
    cur_slave = slave_of(addr);
    exp_aw[cur_slave].push_back(addr);
    aw_addr  = addr;
    aw_valid = 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    #1;
    aw_valid = 1'b0;
    for (int i = 0; i < len; i++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      data    = $urandom;
      strb    = $urandom;
      w_data  = data;
      w_strb  = strb;
      w_last  = (i == len - 1);
      w_valid = 1'b1;
      exp_w[cur_slave].push_back({w_last, strb, data});
      @(posedge clk);
      while (!w_ready) @(posedge clk);
      #1;
      w_valid = 1'b0;
      w_last  = 1'b0;
    end
    done = 1'b0;
    while (!done) begin
      b_ready = ($urandom % 100) >= STALL_PCT;
      @(posedge clk);
      done = b_valid && b_ready;
      if (done) begin
        assert (b_resp == 2'(cur_slave))
        else begin
          value_errs++;
          $display("FAIL b_resp expected %h got %h", 2'(cur_slave), b_resp);
        end
      end
      #1;
    end
    b_ready = 1'b0;
  endtask

  task automatic compare_slave(input int s, input logic [ADDR_W-1:0] got_aw [$],
                               input logic [BEAT_W-1:0] got_w [$]);
    assert (got_aw.size() == exp_aw[s].size())
    else begin
      value_errs++;
      $display("FAIL aw count s%0d expected %h got %h", s, exp_aw[s].size(), got_aw.size());
    end
    for (int i = 0; i < got_aw.size() && i < exp_aw[s].size(); i++) begin
      assert (got_aw[i] == exp_aw[s][i])
      else begin
        value_errs++;
        $display("FAIL aw_addr_s%0d expected %h got %h", s, exp_aw[s][i], got_aw[i]);
      end
    end
    assert (got_w.size() == exp_w[s].size())
    else begin
      value_errs++;
      $display("FAIL w beat count s%0d expected %h got %h", s, exp_w[s].size(), got_w.size());
    end
    // Beat is {w_last, w_strb, w_data}
    for (int i = 0; i < got_w.size() && i < exp_w[s].size(); i++) begin
      assert (got_w[i] == exp_w[s][i])
      else begin
        value_errs++;
        $display("FAIL w_beat_s%0d expected %h got %h", s, exp_w[s][i], got_w[i]);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h61a1));
    value_errs = 0;
    proto_errs = 0;
    b_count    = 0;
    cur_slave  = 0;
    post_reset = 0;
    in_flight  = 1'b0;
    rstn       = 1'b0;
    aw_addr    = '0;
    aw_valid   = 1'b0;
    w_data     = '0;
    w_strb     = '0;
    w_last     = 1'b0;
    w_valid    = 1'b0;
    b_ready    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    for (int t = 0; t < N_TXN; t++) run_txn();
    repeat (4) @(posedge clk);
    compare_slave(0, slv0_i.aw_log, slv0_i.w_log);
    compare_slave(1, slv1_i.aw_log, slv1_i.w_log);
    compare_slave(2, slv2_i.aw_log, slv2_i.w_log);
    assert (b_count == N_TXN)
    else begin
      value_errs++;
      $display("FAIL b count expected %h got %h", N_TXN, b_count);
    end
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
